/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuTb
FILELIST  = project.f

OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) logic/cpu_config.svh sim/cpuTests.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

/* logic/alu.sv */
// ALU with combinational result and a registered zero/carry/negative/overflow flag set
`include "cpu_config.svh"

module alu import cpuPkg::*; (
    input  logic               CLK,
    input  logic               arstN_i,
    input  aluOpT              op_i,
    input  logic               flagWe_i,
    input  logic [`DATA_W-1:0] a_i,
    input  logic [`DATA_W-1:0] b_i,
    output logic [`DATA_W-1:0] result_o,
    output flagsT              flags_o
);

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] opB;
    logic [`DATA_W:0]   sum;
    logic [`DATA_W:0]   diff;
    logic               carry;
    logic               ovf;
    flagsT              nextFlags;

    // INC and DEC use the adder with a constant one
    assign opB  = (op_i == ALU_INC || op_i == ALU_DEC) ? `DATA_W'(1) : b_i;
    assign sum  = {1'b0, a_i} + {1'b0, opB};
    assign diff = {1'b0, a_i} - {1'b0, opB}; // Top bit is the borrow

    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        case (op_i)
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_NOT: result_o = ~a_i;
            ALU_ADD, ALU_INC: begin
                result_o = sum[MSB:0];
                carry    = sum[`DATA_W];
                ovf      = (a_i[MSB] == opB[MSB]) && (result_o[MSB] != a_i[MSB]);
            end
            ALU_SUB, ALU_DEC: begin
                result_o = diff[MSB:0];
                carry    = diff[`DATA_W];
                ovf      = (a_i[MSB] != opB[MSB]) && (result_o[MSB] != a_i[MSB]);
            end
            ALU_LSL: begin
                result_o = {a_i[MSB-1:0], 1'b0};
                carry    = a_i[MSB]; // Bit shifted out
            end
            ALU_LSR: begin
                result_o = {1'b0, a_i[MSB:1]};
                carry    = a_i[0];
            end
            default: result_o = a_i; // PASSA and MOV
        endcase
    end

    assign nextFlags = '{z: (result_o == '0), c: carry, n: result_o[MSB], v: ovf};

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            flags_o <= '0;
        end else if (flagWe_i) begin
            flags_o <= nextFlags; // Only ALU instructions update flags
        end
    end

endmodule

/* logic/controlUnit.sv */
// Control unit sequencing fetch and execute, with branch logic and store credit tracking
`include "cpu_config.svh"

module controlUnit import cpuPkg::*; (
    input  logic               CLK,
    input  logic               arstN_i,
    input  logic               run_i,
    input  logic               storeCredit_i,
    input  logic [`DATA_W-1:0] memData_i,
    input  logic [`DATA_W-1:0] memData2_i,
    input  logic [`DATA_W-1:0] rdA_i,
    input  logic [`DATA_W-1:0] rdB_i,
    input  logic [`DATA_W-1:0] aluResult_i,
    input  flagsT              flags_i,
    output logic [`ADDR_W-1:0] memAddr_o,
    output logic [`ADDR_W-1:0] memAddr2_o,
    output regCtrlT            regCtrl_o,
    output logic [1:0]         rdSelA_o,
    output logic [1:0]         rdSelB_o,
    output aluOpT              aluOp_o,
    output logic               flagWe_o,
    output logic               storeValid_o,
    output storeRecT           store_o,
    output logic               halted_o
);

    localparam int CREDIT_W = $clog2(`STORE_CREDITS + 1);

    seqStateT           state;
    logic [`ADDR_W-1:0] pc;
    instrT              instr;
    logic [CREDIT_W-1:0] credits;
    aluOpT              decodedOp;
    logic               isAluOp;
    logic               storeReq;

    always_comb begin
        isAluOp = 1'b1;
        case (instr.opcode)
            OP_MOV:  decodedOp = ALU_MOV;
            OP_AND:  decodedOp = ALU_AND;
            OP_OR:   decodedOp = ALU_OR;
            OP_NOT:  decodedOp = ALU_NOT;
            OP_ADD:  decodedOp = ALU_ADD;
            OP_SUB:  decodedOp = ALU_SUB;
            OP_LSL:  decodedOp = ALU_LSL;
            OP_LSR:  decodedOp = ALU_LSR;
            OP_INC:  decodedOp = ALU_INC;
            OP_DEC:  decodedOp = ALU_DEC;
            default: begin
                decodedOp = ALU_PASSA;
                isAluOp   = 1'b0;
            end
        endcase
    end

    always_comb begin
        regCtrl_o = '{regOp: REG_HOLD, wrSel: instr.dst, wrData: aluResult_i};
        rdSelA_o  = instr.srcA;
        rdSelB_o  = instr.imm[7:6]; // srcB field
        aluOp_o   = ALU_PASSA;
        flagWe_o  = 1'b0;
        if (state == EXEC) begin
            if (isAluOp) begin
                aluOp_o         = decodedOp;
                flagWe_o        = 1'b1;
                regCtrl_o.regOp = REG_LOAD;
                if (instr.opcode == OP_MOV) begin
                    regCtrl_o.wrData = rdA_i; // Plain copy
                end else if (instr.dst == instr.srcA && instr.opcode == OP_INC) begin
                    regCtrl_o.regOp = REG_INC; // Count in place
                end else if (instr.dst == instr.srcA && instr.opcode == OP_DEC) begin
                    regCtrl_o.regOp = REG_DEC;
                end
            end else if (instr.opcode == OP_LDI) begin
                regCtrl_o.regOp  = REG_LOAD;
                regCtrl_o.wrData = instr.imm;
            end else if (instr.opcode == OP_LDM) begin
                regCtrl_o.regOp  = REG_LOAD;
                regCtrl_o.wrData = memData2_i;
            end
        end
        if (storeReq) begin
            rdSelB_o = instr.dst; // Store data comes out on port B
        end
    end

    assign memAddr_o    = pc;
    assign memAddr2_o   = instr.imm;
    assign storeReq     = (state == EXEC && instr.opcode == OP_ST) || state == STOREWAIT;
    assign storeValid_o = storeReq && credits != '0;
    assign store_o      = '{addr: instr.imm, data: rdB_i};
    assign halted_o     = (state == HALTED);

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE, HALTED: begin
                    if (run_i) begin
                        pc    <= '0; // Restart from address 0
                        state <= FETCHHI;
                    end
                end
                FETCHHI: begin
                    pc    <= pc + 1'b1;
                    state <= FETCHLO;
                end
                FETCHLO: begin
                    pc    <= pc + 1'b1;
                    state <= EXEC;
                end
                EXEC: begin
                    state <= FETCHHI;
                    case (instr.opcode)
                        OP_HALT: state <= HALTED;
                        OP_BRA:  pc <= instr.imm;
                        OP_BNE: begin
                            if (!flags_i.z) begin
                                pc <= instr.imm;
                            end
                        end
                        OP_ST: begin
                            if (!storeValid_o) begin
                                state <= STOREWAIT; // No credit yet
                            end
                        end
                        default: begin
                        end
                    endcase
                end
                STOREWAIT: begin
                    if (storeValid_o) begin
                        state <= FETCHHI;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction register, high byte first
    always_ff @(posedge CLK) begin
        if (state == FETCHHI) begin
            instr[15:8] <= memData_i;
        end else if (state == FETCHLO) begin
            instr[7:0] <= memData_i;
        end
    end

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            credits <= CREDIT_W'(`STORE_CREDITS);
        end else begin
            case ({storeValid_o, storeCredit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // Spent and returned together
            endcase
        end
    end

    creditBound: assert property (
        @(posedge CLK) disable iff (!arstN_i) credits <= CREDIT_W'(`STORE_CREDITS)
    ) else $error("Store credit count above its limit, environment over-returned");

endmodule

/* logic/cpuPkg.sv */
// CPU types shared by the datapath and the sequencer
`include "cpu_config.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OP_BRA  = 4'd0,
        OP_LDI  = 4'd1,
        OP_LDM  = 4'd2,
        OP_ST   = 4'd3,
        OP_MOV  = 4'd4,
        OP_AND  = 4'd5,
        OP_OR   = 4'd6,
        OP_NOT  = 4'd7,
        OP_ADD  = 4'd8,
        OP_SUB  = 4'd9,
        OP_LSL  = 4'd10,
        OP_LSR  = 4'd11,
        OP_INC  = 4'd12,
        OP_DEC  = 4'd13,
        OP_BNE  = 4'd14,
        OP_HALT = 4'd15
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_PASSA, ALU_MOV, ALU_AND, ALU_OR, ALU_NOT, ALU_ADD,
        ALU_SUB, ALU_LSL, ALU_LSR, ALU_INC, ALU_DEC
    } aluOpT;

    typedef enum logic [2:0] {
        IDLE, FETCHHI, FETCHLO, EXEC, STOREWAIT, HALTED
    } seqStateT;

    typedef enum logic [1:0] {
        REG_HOLD, REG_LOAD, REG_INC, REG_DEC
    } regOpT;

    // srcB sits in imm[7:6]
    typedef struct packed {
        opcodeT     opcode;
        logic [1:0] dst;
        logic [1:0] srcA;
        logic [7:0] imm;
    } instrT;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flagsT;

    typedef struct packed {
        regOpT              regOp;
        logic [1:0]         wrSel;
        logic [`DATA_W-1:0] wrData;
    } regCtrlT;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } storeRecT;

endpackage

/* logic/cpuTop.sv */
// CPU top level joining the control unit, register file, ALU and memory
`include "cpu_config.svh"

module cpuTop import cpuPkg::*; (
    input  logic               CLK,
    input  logic               arstN_i,
    input  logic               progWe_i,
    input  logic [`ADDR_W-1:0] progAddr_i,
    input  logic [`DATA_W-1:0] progData_i,
    input  logic               run_i,
    input  logic               storeCredit_i,
    output logic               storeValid_o,
    output storeRecT           store_o,
    output logic               halted_o
);

    logic [`ADDR_W-1:0] memAddr;
    logic [`ADDR_W-1:0] memAddr2;
    logic [`DATA_W-1:0] memData;
    logic [`DATA_W-1:0] memData2;
    logic [`DATA_W-1:0] rdA;
    logic [`DATA_W-1:0] rdB;
    logic [`DATA_W-1:0] aluResult;
    logic [1:0]         rdSelA;
    logic [1:0]         rdSelB;
    regCtrlT            regCtrl;
    aluOpT              aluOp;
    logic               flagWe;
    flagsT              flags;

    controlUnit uCtrl (
        .CLK(CLK), .arstN_i(arstN_i), .run_i(run_i), .storeCredit_i(storeCredit_i),
        .memData_i(memData), .memData2_i(memData2), .rdA_i(rdA), .rdB_i(rdB),
        .aluResult_i(aluResult), .flags_i(flags), .memAddr_o(memAddr),
        .memAddr2_o(memAddr2), .regCtrl_o(regCtrl), .rdSelA_o(rdSelA), .rdSelB_o(rdSelB),
        .aluOp_o(aluOp), .flagWe_o(flagWe), .storeValid_o(storeValid_o),
        .store_o(store_o), .halted_o(halted_o)
    );

    regFile uRegs (
        .CLK(CLK), .arstN_i(arstN_i), .ctrl_i(regCtrl), .rdSelA_i(rdSelA),
        .rdSelB_i(rdSelB), .rdA_o(rdA), .rdB_o(rdB)
    );

    alu uAlu (
        .CLK(CLK), .arstN_i(arstN_i), .op_i(aluOp), .flagWe_i(flagWe), .a_i(rdA),
        .b_i(rdB), .result_o(aluResult), .flags_o(flags)
    );

    progMemory uMem (
        .CLK(CLK), .we_i(progWe_i), .wrAddr_i(progAddr_i), .wrData_i(progData_i),
        .rdAddr_i(memAddr), .rdAddr2_i(memAddr2), .rdData_o(memData), .rdData2_o(memData2)
    );

endmodule

/* logic/cpu_config.svh */
// CPU configuration macros for datapath widths, memory size and store credits
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address widths
`define DATA_W 8
`define ADDR_W 8

// Program and data memory in bytes
`define MEM_DEPTH 256

// General purpose registers
`define NUM_REGS 4

// Credits held by the store channel after reset
`define STORE_CREDITS 4

`endif

/* logic/progMemory.sv */
// Byte memory with a load port, an instruction read port and a data read port
`include "cpu_config.svh"

module progMemory (
    input  logic               CLK,
    input  logic               we_i,
    input  logic [`ADDR_W-1:0] wrAddr_i,
    input  logic [`DATA_W-1:0] wrData_i,
    input  logic [`ADDR_W-1:0] rdAddr_i,
    input  logic [`ADDR_W-1:0] rdAddr2_i,
    output logic [`DATA_W-1:0] rdData_o,
    output logic [`DATA_W-1:0] rdData2_o
);

    logic [`DATA_W-1:0] mem [`MEM_DEPTH];

    // Program load from the testbench side
    always_ff @(posedge CLK) begin
        if (we_i) begin
            mem[wrAddr_i] <= wrData_i;
        end
    end

    assign rdData_o  = mem[rdAddr_i];  // Instruction bytes
    assign rdData2_o = mem[rdAddr2_i]; // LDM operand

endmodule

/* logic/regFile.sv */
// Register file of four general registers with two combinational read ports
`include "cpu_config.svh"

module regFile import cpuPkg::*; (
    input  logic               CLK,
    input  logic               arstN_i,
    input  regCtrlT            ctrl_i,
    input  logic [1:0]         rdSelA_i,
    input  logic [1:0]         rdSelB_i,
    output logic [`DATA_W-1:0] rdA_o,
    output logic [`DATA_W-1:0] rdB_o
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0; // All registers clear
            end
        end else begin
            case (ctrl_i.regOp)
                REG_LOAD: regs[ctrl_i.wrSel] <= ctrl_i.wrData;
                REG_INC:  regs[ctrl_i.wrSel] <= regs[ctrl_i.wrSel] + 1'b1;
                REG_DEC:  regs[ctrl_i.wrSel] <= regs[ctrl_i.wrSel] - 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign rdA_o = regs[rdSelA_i]; // Operand A and in-place source
    assign rdB_o = regs[rdSelB_i]; // Operand B and store data

    // A command from the sequencer must name a known register
    wrSelKnown: assert property (
        @(posedge CLK) disable iff (!arstN_i)
        ctrl_i.regOp != REG_HOLD |-> !$isunknown(ctrl_i.wrSel)
    ) else $error("regFile write select unknown during a register command");

endmodule

/* project.f */
+incdir+logic
+incdir+sim
logic/cpuPkg.sv
logic/regFile.sv
logic/alu.sv
logic/progMemory.sv
logic/controlUnit.sv
logic/cpuTop.sv
sim/cpuTb.sv

/* sim/cpuTests.svh */
// Directed CPU tests covering ALU, loads, branches, store credits and restart
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

task automatic testReset();
    int errStart;
    errStart = errors;
    clearTest();
    if (halted !== 1'b0) begin
        $display("Mismatch halted_o after reset: expected 0x0, got 0x%0h", halted);
        errors++;
    end
    if (storeValid !== 1'b0) begin
        $display("Mismatch storeValid_o after reset: expected 0x0, got 0x%0h", storeValid);
        errors++;
    end
    storeBase = storeQ.size();
    repeat (20) @(negedge CLK); // Idle window without run
    checkStores("idle");
    finishTest("reset and idle", errStart);
endtask

task automatic testAluOps();
    int         errStart;
    logic [7:0] a;
    logic [7:0] b;
    flagsT      f;
    opcodeT     ops[4] = '{OP_ADD, OP_SUB, OP_AND, OP_OR};
    errStart = errors;
    clearTest();
    a = randByte();
    b = randByte();
    emit(OP_LDI, 2'd0, 2'd0, a);
    emit(OP_LDI, 2'd1, 2'd0, b);
    foreach (ops[i]) begin
        emit(ops[i], 2'd2, 2'd0, 8'h40); // r2 = r0 op r1
        emit(OP_ST, 2'd2, 2'd0, 8'(8'h10 + i));
        expectStore(8'(8'h10 + i), modelAlu(ops[i], a, b, f));
    end
    emit(OP_NOT, 2'd2, 2'd0, 8'h00);
    emit(OP_ST, 2'd2, 2'd0, 8'h14);
    emit(OP_MOV, 2'd3, 2'd1, 8'h00);
    emit(OP_ST, 2'd3, 2'd0, 8'h15);
    emit(OP_HALT, 2'd0, 2'd0, 8'h00);
    expectStore(8'h14, modelAlu(OP_NOT, a, b, f));
    expectStore(8'h15, modelAlu(OP_MOV, b, a, f));
    loadProgram();
    startRun();
    waitHalt();
    checkStores("ALU");
    finishTest("ALU operations", errStart);
endtask

task automatic testShiftsAndLoads();
    int         errStart;
    logic [7:0] a;
    logic [7:0] d0;
    logic [7:0] d1;
    flagsT      f;
    errStart = errors;
    clearTest();
    a  = randByte();
    d0 = randByte();
    d1 = randByte();
    writeByte(8'h80, d0); // Data for LDM
    writeByte(8'h81, d1);
    emit(OP_LDI, 2'd0, 2'd0, a);
    emit(OP_LSL, 2'd1, 2'd0, 8'h00);
    emit(OP_ST, 2'd1, 2'd0, 8'h20);
    emit(OP_LSR, 2'd1, 2'd0, 8'h00);
    emit(OP_ST, 2'd1, 2'd0, 8'h21);
    emit(OP_INC, 2'd2, 2'd0, 8'h00);
    emit(OP_ST, 2'd2, 2'd0, 8'h22);
    emit(OP_DEC, 2'd0, 2'd0, 8'h00); // In place
    emit(OP_ST, 2'd0, 2'd0, 8'h23);
    emit(OP_LDM, 2'd3, 2'd0, 8'h80);
    emit(OP_ST, 2'd3, 2'd0, 8'h24);
    emit(OP_LDM, 2'd3, 2'd0, 8'h81);
    emit(OP_ST, 2'd3, 2'd0, 8'h25);
    emit(OP_HALT, 2'd0, 2'd0, 8'h00);
    expectStore(8'h20, modelAlu(OP_LSL, a, 8'h00, f));
    expectStore(8'h21, modelAlu(OP_LSR, a, 8'h00, f));
    expectStore(8'h22, modelAlu(OP_INC, a, 8'h00, f));
    expectStore(8'h23, modelAlu(OP_DEC, a, 8'h00, f));
    expectStore(8'h24, d0);
    expectStore(8'h25, d1);
    loadProgram();
    startRun();
    waitHalt();
    checkStores("shifts and loads");
    finishTest("shifts, counts and memory loads", errStart);
endtask

task automatic testBranches();
    int         errStart;
    int         guard;
    logic [7:0] v;
    flagsT      f;
    errStart = errors;
    clearTest();
    emit(OP_LDI, 2'd0, 2'd0, 8'd5);
    emit(OP_DEC, 2'd0, 2'd0, 8'h00);   // Loop head at byte 2
    emit(OP_ST, 2'd0, 2'd0, 8'h30);
    emit(OP_BNE, 2'd0, 2'd0, 8'd2);
    emit(OP_BRA, 2'd0, 2'd0, 8'd12);
    emit(OP_ST, 2'd0, 2'd0, 8'h3f);    // Skipped
    emit(OP_HALT, 2'd0, 2'd0, 8'h00);
    v     = 8'd5;
    guard = 0;
    f     = '0;
    while (!f.z && guard < 16) begin
        v = modelAlu(OP_DEC, v, 8'h00, f);
        expectStore(8'h30, v);
        guard++;
    end
    loadProgram();
    startRun();
    waitHalt();
    checkStores("branches");
    finishTest("branch loop and jump", errStart);
endtask

task automatic testBackPressure();
    int         errStart;
    logic [7:0] v;
    flagsT      f;
    errStart = errors;
    clearTest();
    v = 8'd0;
    emit(OP_LDI, 2'd0, 2'd0, 8'd0);
    for (int i = 0; i < 8; i++) begin
        emit(OP_INC, 2'd0, 2'd0, 8'h00);
        emit(OP_ST, 2'd0, 2'd0, 8'(8'h40 + i));
        v = modelAlu(OP_INC, v, 8'h00, f);
        expectStore(8'(8'h40 + i), v);
    end
    emit(OP_HALT, 2'd0, 2'd0, 8'h00);
    loadProgram();
    autoCredit = 1'b0; // Withhold credits
    startRun();
    waitStores(`STORE_CREDITS);
    repeat (50) @(negedge CLK);
    if (storeQ.size() - storeBase != `STORE_CREDITS) begin
        $display("Mismatch storeValid_o count while stalled: expected 0x%0h, got 0x%0h",
                 `STORE_CREDITS, storeQ.size() - storeBase);
        errors++;
    end
    autoCredit  = 1'b1;
    grantTarget = `STORE_CREDITS; // Refill the spent credits
    waitHalt();
    checkStores("back-pressure");
    finishTest("store back-pressure", errStart);
endtask

task automatic testHaltRestart();
    int         errStart;
    int         drops;
    logic [7:0] x;
    flagsT      f;
    errStart = errors;
    drops    = 0;
    clearTest();
    x = randByte();
    emit(OP_LDI, 2'd1, 2'd0, x);
    emit(OP_ST, 2'd1, 2'd0, 8'h50);
    emit(OP_INC, 2'd1, 2'd1, 8'h00);
    emit(OP_ST, 2'd1, 2'd0, 8'h51);
    emit(OP_HALT, 2'd0, 2'd0, 8'h00);
    expectStore(8'h50, x);
    expectStore(8'h51, modelAlu(OP_INC, x, 8'h00, f));
    loadProgram();
    startRun();
    waitHalt();
    repeat (30) begin
        @(negedge CLK);
        if (halted !== 1'b1) begin
            drops++;
        end
    end
    if (drops != 0) begin
        $display("Mismatch halted_o after HALT: expected 0x1, got 0x0 in %0d cycles", drops);
        errors++;
    end
    checkStores("first run"); // Nothing extra while halted
    startRun();
    waitHalt();
    checkStores("second run");
    finishTest("halt and restart", errStart);
endtask

`endif

/* sim/cpuTb.sv */
// Testbench for the CPU top level with program load, store collection and credit return
`include "cpu_config.svh"

module cpuTb import cpuPkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RUN_TIMEOUT = 2000;
    localparam logic [31:0] SEED        = 32'h1f90;

    logic           CLK;
    logic           arstN;
    logic           progWe;
    logic [7:0]     progAddr;
    logic [7:0]     progData;
    logic           run;
    logic           storeCredit = 1'b0;
    logic           storeValid;
    storeRecT       storeRec;
    logic           halted;

    instrT          progQ[$];   // Program under construction
    storeRecT       storeQ[$];  // Every record seen on the store channel
    storeRecT       expQ[$];
    int             storeBase;  // First record of the current run
    int             errors      = 0;
    int             testsRun    = 0;
    int             testsFailed = 0;
    bit             autoCredit  = 1'b1;
    int             grantTarget = 0;
    int             grantsGiven = 0;
    logic           creditNext  = 1'b0;

    cpuTop uut (
        .CLK(CLK), .arstN_i(arstN), .progWe_i(progWe), .progAddr_i(progAddr),
        .progData_i(progData), .run_i(run), .storeCredit_i(storeCredit),
        .storeValid_o(storeValid), .store_o(storeRec), .halted_o(halted)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Collector samples before the edge updates the DUT
    always @(posedge CLK) begin
        if (storeValid) begin
            storeQ.push_back(storeRec);
        end
        if (autoCredit && storeValid) begin
            creditNext = 1'b1; // Hand back the credit just spent
        end else if (grantsGiven < grantTarget) begin
            creditNext = 1'b1;
            grantsGiven++;
        end else begin
            creditNext = 1'b0;
        end
    end

    always @(negedge CLK) begin
        storeCredit = creditNext;
    end

    function automatic logic [7:0] randByte();
        return 8'($urandom);
    endfunction

    // Reference ALU with z, c, n, v from the instruction set rules
    function automatic logic [7:0] modelAlu(input opcodeT op, input logic [7:0] a,
                                            input logic [7:0] b, output flagsT f);
        logic [7:0] r;
        logic [7:0] bb;
        int         full;
        int         sfull;
        bb = (op == OP_INC || op == OP_DEC) ? 8'd1 : b;
        f  = '0;
        r  = a; // MOV copies
        case (op)
            OP_ADD, OP_INC: begin
                full  = int'(a) + int'(bb);
                sfull = int'($signed(a)) + int'($signed(bb));
                r     = 8'(full);
                f.c   = full > 255; // Carry out
                f.v   = sfull > 127 || sfull < -128;
            end
            OP_SUB, OP_DEC: begin
                full  = int'(a) - int'(bb);
                sfull = int'($signed(a)) - int'($signed(bb));
                r     = 8'(full);
                f.c   = full < 0; // Borrow
                f.v   = sfull > 127 || sfull < -128;
            end
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_NOT: r = ~a;
            OP_LSL: begin
                r   = a << 1;
                f.c = a[7];
            end
            OP_LSR: begin
                r   = a >> 1;
                f.c = a[0];
            end
            default: begin
            end
        endcase
        f.z = (r == 8'd0);
        f.n = r[7];
        return r;
    endfunction

    task automatic emit(input opcodeT op, input logic [1:0] dst, input logic [1:0] srcA,
                        input logic [7:0] imm);
        instrT w;
        w.opcode = op;
        w.dst    = dst;
        w.srcA   = srcA;
        w.imm    = imm; // srcB rides in the top two bits
        progQ.push_back(w);
    endtask

    task automatic expectStore(input logic [7:0] addr, input logic [7:0] data);
        storeRecT r;
        r.addr = addr;
        r.data = data;
        expQ.push_back(r);
    endtask

    task automatic clearTest();
        progQ.delete();
        expQ.delete();
    endtask

    task automatic writeByte(input logic [7:0] addr, input logic [7:0] data);
        @(negedge CLK);
        progWe   = 1'b1;
        progAddr = addr;
        progData = data;
        @(negedge CLK);
        progWe = 1'b0;
    endtask

    // High byte of each word at the even address
    task automatic loadProgram();
        foreach (progQ[i]) begin
            writeByte(8'(2 * i), progQ[i][15:8]);
            writeByte(8'(2 * i + 1), progQ[i][7:0]);
        end
    endtask

    task automatic startRun();
        storeBase = storeQ.size();
        @(negedge CLK);
        run = 1'b1;
        @(negedge CLK);
        run = 1'b0;
    endtask

    task automatic waitHalt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < RUN_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the program did not reach HALT within %0d cycles", RUN_TIMEOUT);
            errors++;
        end
    endtask

    task automatic waitStores(input int count);
        int cycles;
        cycles = 0;
        while (storeQ.size() - storeBase < count && cycles < RUN_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (storeQ.size() - storeBase < count) begin
            $display("Timeout: only %0d of %0d store records arrived",
                     storeQ.size() - storeBase, count);
            errors++;
        end
    endtask

    task automatic checkStores(input string what);
        int       got;
        storeRecT rec;
        got = storeQ.size() - storeBase;
        if (got != expQ.size()) begin
            $display("Mismatch storeValid_o count (%s): expected 0x%0h, got 0x%0h",
                     what, expQ.size(), got);
            errors++;
        end
        for (int i = 0; i < got && i < expQ.size(); i++) begin
            rec = storeQ[storeBase + i];
            if (rec !== expQ[i]) begin
                $display("Mismatch store_o[%0d] (%s): expected 0x%02h/0x%02h, got 0x%02h/0x%02h",
                         i, what, expQ[i].addr, expQ[i].data, rec.addr, rec.data);
                errors++;
            end
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        testsRun++;
        if (errors == errStart) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errors - errStart);
        end
    endtask

`include "cpuTests.svh"

    initial begin
        arstN    = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        run      = 1'b0;
        void'($urandom(SEED));
        repeat (16) @(negedge CLK);
        arstN = 1'b1;
        testReset();
        testAluOps();
        testShiftsAndLoads();
        testBranches();
        testBackPressure();
        testHaltRestart();
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
